// ==== hw/mul_width_pkg.sv ====
/*
 * Width definitions for the signed multiplier
 *  - word and double-word vector types
 *  - row stepping constants for the execute array
 *  - overflow limits on the product magnitude
 */

package mul_width_pkg;

	// Operand and result width
	localparam int WORD_W = 32;
	localparam int DWORD_W = 2 * WORD_W;

	// Partial-product rows added per clock cycle
	localparam int ROWS_PER_STEP = 4;
	localparam int STEP_COUNT = WORD_W / ROWS_PER_STEP;
	localparam int STEP_W = $clog2(STEP_COUNT + 1);

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [DWORD_W-1:0] dword_t;
	typedef logic [STEP_W-1:0]  step_t;

	// Largest magnitude of a positive result, 2^31 - 1
	localparam dword_t POS_MAG_MAX = {{(WORD_W + 1){1'b0}}, {(WORD_W - 1){1'b1}}};

	// Largest magnitude of a negative result, 2^31
	localparam dword_t NEG_MAG_MAX = {{WORD_W{1'b0}}, 1'b1, {(WORD_W - 1){1'b0}}};

endpackage

// ==== hw/mul_ctrl_pkg.sv ====
/*
 * Control types passed between the multiplier stages
 *  - decoded operand magnitudes with the product sign
 *  - unsigned product magnitude with the product sign
 *  - execute FSM states
 */

package mul_ctrl_pkg;

	import mul_width_pkg::*;

	// Decode to execute
	typedef struct packed {
		word_t mag_a;
		word_t mag_b;
		// Product is negative
		logic  neg;
	} decoded_ops_t;

	// Execute to result
	typedef struct packed {
		dword_t mag;
		logic   neg;
	} magnitude_t;

	// Execute FSM
	typedef enum logic {
		EXEC_IDLE,
		EXEC_RUN
	} exec_state_t;

endpackage

// ==== hw/mul_operand_decode.sv ====
/*
 * Operand decode stage
 *  - accepts ctrl_mult only when the unit is free
 *  - registers the absolute value of each operand
 *  - registers the product sign as the xor of the operand signs
 */

`timescale 1ns/1ps

module mul_operand_decode
	import mul_width_pkg::*, mul_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         ctrl_mult,
	input  word_t        data_operand_a,
	input  word_t        data_operand_b,
	input  logic         busy,
	output decoded_ops_t ops,
	output logic         ops_valid
);

	logic  accept;
	word_t abs_a;
	word_t abs_b;

	// Strobes during an operation are dropped
	assign accept = ctrl_mult && !busy && !ops_valid;

	// Magnitude of the most negative word still fits unsigned
	assign abs_a = data_operand_a[WORD_W-1] ? -data_operand_a : data_operand_a;
	assign abs_b = data_operand_b[WORD_W-1] ? -data_operand_b : data_operand_b;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ops_valid <= 1'b0;
		end else begin
			ops_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ops.mag_a <= abs_a;
			ops.mag_b <= abs_b;
			ops.neg   <= data_operand_a[WORD_W-1] ^ data_operand_b[WORD_W-1];
		end
	end

	// Execute must be free whenever a new operation is handed over
	assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ops_valid) |-> !busy)
	else $error("ops_valid rose while execute was busy");

endmodule

// ==== hw/mul_array_execute.sv ====
/*
 * Execute stage of the multiplier
 *  - unsigned shift-and-add over rows of full adders
 *  - ROWS_PER_STEP rows per clock, STEP_COUNT steps per operation
 *  - busy back to decode and the product magnitude to result
 */

`timescale 1ns/1ps

module mul_array_execute
	import mul_width_pkg::*, mul_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  decoded_ops_t ops,
	input  logic         ops_valid,
	output logic         busy,
	output magnitude_t   mag_out,
	output logic         mag_valid
);

	exec_state_t state;
	step_t       step_cnt;
	word_t       mag_a_q;
	word_t       b_rem_q;
	dword_t      acc_q;
	logic        neg_q;

	logic        start;
	logic        step_en;
	logic        last_step;
	word_t       a_src;
	word_t       b_src;
	dword_t      acc_next;

	assign start     = (state == EXEC_IDLE) && ops_valid;
	assign step_en   = start || (state == EXEC_RUN);
	assign last_step = (step_cnt == step_t'(STEP_COUNT - 1));

	// First step works straight from the decoded operands
	assign a_src = (state == EXEC_IDLE) ? ops.mag_a : mag_a_q;
	assign b_src = (state == EXEC_IDLE) ? ops.mag_b : b_rem_q;

	// Rows of full adders, each adding A AND one bit of B into the upper half.
	// The sum then shifts right so bit 0 of every row drops out as a product bit.
	always_comb begin
		dword_t acc;
		word_t  row_sum;
		logic   carry;
		logic   pp;
		logic   upper;

		acc = (state == EXEC_IDLE) ? '0 : acc_q;
		for (int r = 0; r < ROWS_PER_STEP; r++) begin
			carry = 1'b0;
			for (int i = 0; i < WORD_W; i++) begin
				pp         = a_src[i] & b_src[r];
				upper      = acc[WORD_W+i];
				row_sum[i] = pp ^ upper ^ carry;
				carry      = (pp & upper) | (carry & (pp ^ upper));
			end
			acc = {carry, row_sum, acc[WORD_W-1:1]};
		end
		acc_next = acc;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= EXEC_IDLE;
			step_cnt  <= '0;
			mag_valid <= 1'b0;
		end else begin
			mag_valid <= 1'b0;
			case (state)
				EXEC_IDLE: begin
					if (ops_valid) begin
						state    <= EXEC_RUN;
						step_cnt <= step_t'(1);
					end
				end
				EXEC_RUN: begin
					if (last_step) begin
						state     <= EXEC_IDLE;
						step_cnt  <= '0;
						mag_valid <= 1'b1;
					end else begin
						step_cnt <= step_cnt + step_t'(1);
					end
				end
				default: state <= EXEC_IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (step_en) begin
			mag_a_q <= a_src;
			b_rem_q <= b_src >> ROWS_PER_STEP;
			acc_q   <= acc_next;
		end
		if (start) begin
			neg_q <= ops.neg;
		end
	end

	// Product holds in acc_q until the next start
	assign mag_out.mag = acc_q;
	assign mag_out.neg = neg_q;

	// Also covers the cycle where result samples the product
	assign busy = (state == EXEC_RUN) || mag_valid;

	assert property (@(posedge clk) disable iff (!arst_n)
		(state == EXEC_RUN) |-> (step_cnt < step_t'(STEP_COUNT)))
	else $error("step counter out of range");

	// Product is handed over only after all STEP_COUNT steps
	assert property (@(posedge clk) disable iff (!arst_n)
		mag_valid |-> $past(start, STEP_COUNT))
	else $error("mag_valid not STEP_COUNT cycles after start");

endmodule

// ==== hw/mul_result_sign.sv ====
/*
 * Result stage of the multiplier
 *  - restores the sign of the 64-bit product
 *  - flags products outside the signed 32-bit range
 *  - registers result, exception and the ready pulse
 */

`timescale 1ns/1ps

module mul_result_sign
	import mul_width_pkg::*, mul_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  magnitude_t mag_in,
	input  logic       mag_valid,
	output word_t      data_result,
	output logic       data_exception,
	output logic       data_result_rdy
);

	dword_t prod_signed;
	logic   overflow;

	assign prod_signed = mag_in.neg ? -mag_in.mag : mag_in.mag;

	// Negative side reaches one further than the positive side
	assign overflow = mag_in.neg ? (mag_in.mag > NEG_MAG_MAX)
	                             : (mag_in.mag > POS_MAG_MAX);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_result     <= '0;
			data_exception  <= 1'b0;
			data_result_rdy <= 1'b0;
		end else begin
			data_result_rdy <= mag_valid;
			// Outputs hold until the next product arrives
			if (mag_valid) begin
				data_result    <= prod_signed[WORD_W-1:0];
				data_exception <= overflow;
			end
		end
	end

	// One operation in flight means one isolated pulse
	assert property (@(posedge clk) disable iff (!arst_n)
		data_result_rdy |=> !data_result_rdy)
	else $error("data_result_rdy high for two cycles");

endmodule

// ==== hw/signed_multiplier.sv ====
/*
 * Signed 32x32 multiplier top level
 *  - operand decode, row-array execute and sign/overflow result stages
 *  - one operation in flight, ready pulse nine edges after the strobe
 */

`timescale 1ns/1ps

module signed_multiplier
	import mul_width_pkg::*, mul_ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  ctrl_mult,
	input  word_t data_operand_a,
	input  word_t data_operand_b,
	output word_t data_result,
	output logic  data_exception,
	output logic  data_result_rdy
);

	decoded_ops_t ops;
	logic         ops_valid;
	logic         busy;
	magnitude_t   mag;
	logic         mag_valid;

	mul_operand_decode u_decode (
		.clk            (clk),
		.arst_n         (arst_n),
		.ctrl_mult      (ctrl_mult),
		.data_operand_a (data_operand_a),
		.data_operand_b (data_operand_b),
		.busy           (busy),
		.ops            (ops),
		.ops_valid      (ops_valid)
	);

	mul_array_execute u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.ops       (ops),
		.ops_valid (ops_valid),
		.busy      (busy),
		.mag_out   (mag),
		.mag_valid (mag_valid)
	);

	mul_result_sign u_result (
		.clk             (clk),
		.arst_n          (arst_n),
		.mag_in          (mag),
		.mag_valid       (mag_valid),
		.data_result     (data_result),
		.data_exception  (data_exception),
		.data_result_rdy (data_result_rdy)
	);

endmodule

// ==== sim/mul_checker.sv ====
/*
 * Result checker for the signed multiplier testbench
 *  - records the operands of each accepted strobe
 *  - computes the exact signed product and the overflow rule
 *  - checks ready latency, result and exception, one line per test
 */

`timescale 1ns/1ps

module mul_checker
	import mul_width_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         ctrl_mult,
	input  word_t        data_operand_a,
	input  word_t        data_operand_b,
	input  logic [127:0] test_name,
	input  word_t        data_result,
	input  logic         data_exception,
	input  logic         data_result_rdy,
	output int           tests_done,
	output int           fail_count
);

	// Edges from the strobe edge to the edge that raises ready
	localparam int     RDY_LATENCY = 9;
	localparam longint RESULT_MAX  = 64'sd2147483647;
	localparam longint RESULT_MIN  = -64'sd2147483648;

	int           edge_cnt;
	int           accept_edge;
	logic         pending;
	word_t        op_a;
	word_t        op_b;
	logic [127:0] op_name;

	// Exact product, then the low word and the signed 32-bit range test
	function automatic void expected_of(input word_t a, input word_t b,
		output word_t res, output logic exc);
		longint prod;
		prod = longint'($signed(a)) * longint'($signed(b));
		res  = prod[WORD_W-1:0];
		exc  = (prod > RESULT_MAX) || (prod < RESULT_MIN);
	endfunction

	task automatic check_result();
		word_t exp_res;
		logic  exp_exc;
		int    latency;
		// Ready is seen here one edge after the DUT raised it
		latency = edge_cnt - accept_edge - 1;
		expected_of(op_a, op_b, exp_res, exp_exc);
		tests_done++;
		if (latency != RDY_LATENCY) begin
			fail_count++;
			$display("[FAIL] %0s: ready latency expected %0d edges, actual %0d",
				op_name, RDY_LATENCY, latency);
		end else if (data_result !== exp_res || data_exception !== exp_exc) begin
			fail_count++;
			$display("[FAIL] %0s: expected result %h exception %b, actual result %h exception %b",
				op_name, exp_res, exp_exc, data_result, data_exception);
		end else begin
			$display("[PASS] %0s: result %h exception %b", op_name, data_result, data_exception);
		end
	endtask

	always @(posedge clk) begin
		if (!arst_n) begin
			edge_cnt    = 0;
			accept_edge = 0;
			pending     = 1'b0;
			tests_done  = 0;
			fail_count  = 0;
		end else begin
			edge_cnt++;
			if (data_result_rdy) begin
				if (pending) begin
					check_result();
					pending = 1'b0;
				end else begin
					fail_count++;
					$display("Unexpected data_result_rdy pulse with no multiply in flight");
				end
			end else if (pending && (edge_cnt - accept_edge > RDY_LATENCY + 1)) begin
				fail_count++;
				$display("No data_result_rdy pulse for %0s within %0d edges",
					op_name, RDY_LATENCY);
				pending = 1'b0;
			end
			// Strobe is taken only when nothing is in flight
			if (ctrl_mult && !pending) begin
				pending     = 1'b1;
				accept_edge = edge_cnt;
				op_a        = data_operand_a;
				op_b        = data_operand_b;
				op_name     = test_name;
			end
		end
	end

endmodule

// ==== sim/tb_signed_multiplier.sv ====
/*
 * Testbench for the signed multiplier
 *  - clock, reset and the cycle limit
 *  - stimulus table with fixed and LCG entries
 *  - strobe driver loop and the checker instance
 */

`timescale 1ns/1ps

module tb_signed_multiplier
	import mul_width_pkg::*;
();

	localparam int NUM_FIXED       = 10;
	localparam int NUM_RANDOM      = 20;
	localparam int NUM_TESTS       = NUM_FIXED + NUM_RANDOM;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_TEST = 12;
	localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES + 50;
	localparam logic [31:0] LCG_SEED = 32'hd67d_5ff5;

	// Operands of the strobe sent while the unit is busy
	localparam word_t ALT_A = 32'h0000_0400;
	localparam word_t ALT_B = 32'h0000_0100;

	typedef logic [8*16-1:0] name_t;

	typedef struct packed {
		name_t name;
		word_t a;
		word_t b;
		// Second strobe three cycles after the first
		logic  second;
	} stim_t;

	logic  clk;
	logic  arst_n;
	logic  ctrl_mult;
	word_t data_operand_a;
	word_t data_operand_b;
	name_t test_name;
	word_t data_result;
	logic  data_exception;
	logic  data_result_rdy;
	int    tests_done;
	int    fail_count;
	int    cycle_cnt = 0;
	stim_t stim_table [NUM_TESTS];

	signed_multiplier UUT (
		.clk             (clk),
		.arst_n          (arst_n),
		.ctrl_mult       (ctrl_mult),
		.data_operand_a  (data_operand_a),
		.data_operand_b  (data_operand_b),
		.data_result     (data_result),
		.data_exception  (data_exception),
		.data_result_rdy (data_result_rdy)
	);

	mul_checker u_checker (
		.clk             (clk),
		.arst_n          (arst_n),
		.ctrl_mult       (ctrl_mult),
		.data_operand_a  (data_operand_a),
		.data_operand_b  (data_operand_b),
		.test_name       (test_name),
		.data_result     (data_result),
		.data_exception  (data_exception),
		.data_result_rdy (data_result_rdy),
		.tests_done      (tests_done),
		.fail_count      (fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic stim_t make_stim(input name_t name, input word_t a, input word_t b,
		input logic second);
		stim_t s;
		s.name   = name;
		s.a      = a;
		s.b      = b;
		s.second = second;
		return s;
	endfunction

	function automatic name_t rand_name(input int idx);
		return name_t'({"rand_", 8'(48 + idx / 10), 8'(48 + idx % 10)});
	endfunction

	task automatic load_table();
		logic [31:0] seed;
		word_t       a;
		stim_table[0] = make_stim("zero_times_x", 32'h0000_0000, 32'h1234_5678, 1'b0);
		stim_table[1] = make_stim("seven_six", 32'h0000_0007, 32'h0000_0006, 1'b0);
		stim_table[2] = make_stim("neg1_neg1", 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		stim_table[3] = make_stim("three_neg5", 32'h0000_0003, 32'hffff_fffb, 1'b0);
		stim_table[4] = make_stim("min_times_1", 32'h8000_0000, 32'h0000_0001, 1'b0);
		stim_table[5] = make_stim("neg64k_32k", 32'hffff_0000, 32'h0000_8000, 1'b0);
		stim_table[6] = make_stim("64k_squared", 32'h0001_0000, 32'h0001_0000, 1'b0);
		stim_table[7] = make_stim("max_squared", 32'h7fff_ffff, 32'h7fff_ffff, 1'b0);
		stim_table[8] = make_stim("min_neg1", 32'h8000_0000, 32'hffff_ffff, 1'b0);
		stim_table[9] = make_stim("busy_strobe", 32'h0000_04d2, 32'hffff_ff9d, 1'b1);
		seed = LCG_SEED;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			seed = lcg_next(seed);
			a    = seed;
			seed = lcg_next(seed);
			stim_table[NUM_FIXED + i] = make_stim(rand_name(i), a, seed, 1'b0);
		end
	endtask

	task automatic wait_ready();
		do begin
			@(posedge clk);
		end while (!data_result_rdy);
	endtask

	task automatic apply_entry(input stim_t s);
		@(posedge clk);
		ctrl_mult      <= 1'b1;
		data_operand_a <= s.a;
		data_operand_b <= s.b;
		test_name      <= s.name;
		@(posedge clk);
		ctrl_mult <= 1'b0;
		if (s.second) begin
			repeat (2) @(posedge clk);
			ctrl_mult      <= 1'b1;
			data_operand_a <= ALT_A;
			data_operand_b <= ALT_B;
			@(posedge clk);
			ctrl_mult <= 1'b0;
		end
		wait_ready();
		// Two idle cycles before the next strobe
		@(posedge clk);
	endtask

	initial begin
		arst_n         = 1'b0;
		ctrl_mult      = 1'b0;
		data_operand_a = '0;
		data_operand_b = '0;
		test_name      = '0;
		load_table();
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < NUM_TESTS; i++) begin
			apply_entry(stim_table[i]);
		end
		// Room for a stray ready pulse to show up
		repeat (4) @(posedge clk);
		$display("Tests checked: %0d of %0d, failed: %0d", tests_done, NUM_TESTS, fail_count);
		if (fail_count == 0 && tests_done == NUM_TESTS) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

endmodule

// ==== src.f ====
hw/mul_width_pkg.sv
hw/mul_ctrl_pkg.sv
hw/mul_operand_decode.sv
hw/mul_array_execute.sv
hw/mul_result_sign.sv
hw/signed_multiplier.sv
sim/mul_checker.sv
sim/tb_signed_multiplier.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_signed_multiplier
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
FAIL_MSG   = Some tests failed
PASS_MSG   = All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
